// File: hdl/div_controller.sv
/*
 * Sequencer for the shared-adder divider datapath.
 * Runs four setup states, DIV_WIDTH+1 non-restoring steps and three
 * finishing states; done_o pulses in the cycle after S_QUOT.
 * A zero divisor leaves the quotient unsigned, so it reads as all ones.
 */

`timescale 1ns/100ps
`default_nettype none

module div_controller import div_pkg::*; (
	input  logic       clk_i,
	input  logic       reset_i,
	input  logic       start_v_i,
	input  logic       signed_i,
	input  logic       adder_neg_i,
	input  logic       opa_neg_i,
	input  logic       opc_neg_i,
	output logic       idle_o,
	output logic       done_o,
	output logic       opa_sel_o,
	output logic       opa_ld_o,
	output logic       opa_inv_o,
	output logic       opa_clr_l_o,
	output logic [2:0] opb_sel_o,
	output logic       opb_ld_o,
	output logic       opb_inv_o,
	output logic       opb_clr_l_o,
	output logic [2:0] opc_sel_o,
	output logic       opc_ld_o,
	output logic       adder_cin_o
);

	div_state_e state_r;
	div_state_e state_n;
	logic [DIV_CNT_W-1:0] step_cnt_r;
	logic add_neg_last_r;
	logic q_neg_r;
	logic r_neg_r;
	logic neg_ld;
	logic last_step;

	assign last_step = (step_cnt_r == '0);
	assign idle_o = (state_r == S_WAIT) & ~done_o;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_r <= S_WAIT;
			done_o <= 1'b0;
		end else begin
			state_r <= state_n;
			done_o <= (state_r == S_QUOT);
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_r == S_SHIFT) begin
			step_cnt_r <= DIV_CNT_W'(DIV_WIDTH);
		end else if (state_r == S_CALC) begin
			step_cnt_r <= step_cnt_r - 1'b1;
		end
	end

	// sign of the previous step picks add or subtract for the next one.
	always_ff @(posedge clk_i) begin
		add_neg_last_r <= adder_neg_i;
		if (neg_ld) begin
			// in S_NEG0 the adder sign is set only for a nonzero divisor.
			q_neg_r <= (opa_neg_i ^ opc_neg_i) & signed_i & adder_neg_i;
			r_neg_r <= opc_neg_i & signed_i;
		end
	end

	always_comb begin
		state_n = S_WAIT;
		opa_sel_o = 1'b0;
		opa_ld_o = 1'b0;
		opa_inv_o = ~add_neg_last_r;
		opa_clr_l_o = 1'b1;
		opb_sel_o = 3'b001;
		opb_ld_o = 1'b1;
		opb_inv_o = 1'b0;
		opb_clr_l_o = 1'b1;
		opc_sel_o = 3'b001;
		opc_ld_o = 1'b1;
		adder_cin_o = ~add_neg_last_r;
		neg_ld = 1'b0;
		case (state_r)
			S_WAIT: begin
				state_n = start_v_i ? S_START : S_WAIT;
				opb_ld_o = 1'b0;
				opc_ld_o = 1'b0;
			end
			S_START: begin
				state_n = S_NEG0;
				opa_sel_o = 1'b1;
				opa_ld_o = 1'b1;
				opb_ld_o = 1'b0;
				opc_sel_o = 3'b100;
			end
			// negate the divisor and copy the dividend into B.
			S_NEG0: begin
				state_n = S_NEG1;
				opa_ld_o = opa_neg_i & signed_i;
				opa_inv_o = 1'b1;
				opb_sel_o = 3'b100;
				opb_clr_l_o = 1'b0;
				opc_ld_o = 1'b0;
				adder_cin_o = 1'b1;
				neg_ld = 1'b1;
			end
			S_NEG1: begin
				state_n = S_SHIFT;
				opa_clr_l_o = 1'b0;
				opb_inv_o = 1'b1;
				opb_ld_o = 1'b0;
				opc_sel_o = 3'b010;
				opc_ld_o = opc_neg_i & signed_i;
				adder_cin_o = 1'b1;
			end
			S_SHIFT: begin
				state_n = S_CALC;
				opa_clr_l_o = 1'b0;
				opb_clr_l_o = 1'b0;
				adder_cin_o = 1'b0;
			end
			S_CALC: begin
				state_n = last_step ? S_REPAIR : S_CALC;
				// the last step keeps the remainder unshifted.
				if (last_step) begin
					opb_sel_o = 3'b010;
				end
			end
			S_REPAIR: begin
				state_n = S_REMAIN;
				opa_inv_o = 1'b0;
				opb_sel_o = 3'b010;
				opb_ld_o = add_neg_last_r;
				opc_ld_o = 1'b0;
				adder_cin_o = 1'b0;
			end
			S_REMAIN: begin
				state_n = S_QUOT;
				opa_ld_o = 1'b1;
				opa_clr_l_o = 1'b0;
				opb_sel_o = 3'b100;
				opb_inv_o = r_neg_r;
				opc_ld_o = 1'b0;
				adder_cin_o = r_neg_r;
			end
			S_QUOT: begin
				state_n = S_WAIT;
				opa_clr_l_o = 1'b0;
				opb_inv_o = 1'b1;
				opb_ld_o = 1'b0;
				opc_sel_o = 3'b010;
				opc_ld_o = q_neg_r;
				adder_cin_o = 1'b1;
			end
			default: state_n = S_WAIT;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/div_datapath.sv
/*
 * Shared-adder datapath of the divider.
 * A holds the divisor and later the remainder, B the partial remainder,
 * C the dividend and later the quotient. The adder and B carry one guard
 * bit. Selects are one-hot; every decision comes from the controller.
 */

`timescale 1ns/100ps
`default_nettype none

module div_datapath import div_pkg::*; (
	input  logic                 clk_i,
	input  logic [DIV_WIDTH-1:0] opa_in_i,
	input  logic [DIV_WIDTH-1:0] opc_in_i,
	input  logic                 opa_sel_i,
	input  logic                 opa_ld_i,
	input  logic                 opa_inv_i,
	input  logic                 opa_clr_l_i,
	input  logic [2:0]           opb_sel_i,
	input  logic                 opb_ld_i,
	input  logic                 opb_inv_i,
	input  logic                 opb_clr_l_i,
	input  logic [2:0]           opc_sel_i,
	input  logic                 opc_ld_i,
	input  logic                 adder_cin_i,
	output logic                 adder_neg_o,
	output logic                 opa_neg_o,
	output logic                 opc_neg_o,
	output logic [DIV_WIDTH-1:0] opa_o,
	output logic [DIV_WIDTH-1:0] opc_o
);

	localparam int unsigned XW = DIV_WIDTH + 1;

	logic [DIV_WIDTH-1:0] opa_r;
	logic [XW-1:0] opb_r;
	logic [XW-1:0] opc_r;
	logic [DIV_WIDTH-1:0] opa_mux;
	logic [XW-1:0] opb_mux;
	logic [XW-1:0] opc_mux;
	logic [XW-1:0] opa_term;
	logic [XW-1:0] opb_term;
	logic [XW-1:0] add_out;

	// A enters the adder zero-extended.
	assign opa_term = ({1'b0, opa_r} ^ {XW{opa_inv_i}}) & {XW{opa_clr_l_i}};
	assign opb_term = (opb_r ^ {XW{opb_inv_i}}) & {XW{opb_clr_l_i}};
	assign add_out = opa_term + opb_term + {{DIV_WIDTH{1'b0}}, adder_cin_i};

	assign opa_mux = opa_sel_i ? opa_in_i : add_out[DIV_WIDTH-1:0];

	// 100 copies C, 010 takes the sum, 001 shifts the next dividend bit in.
	assign opb_mux = ({XW{opb_sel_i[2]}} & opc_r) |
		({XW{opb_sel_i[1]}} & add_out) |
		({XW{opb_sel_i[0]}} & {add_out[DIV_WIDTH-1:0], opc_r[DIV_WIDTH]});

	// the shift path feeds in the inverted adder sign as a quotient bit.
	assign opc_mux = ({XW{opc_sel_i[2]}} & {1'b0, opc_in_i}) |
		({XW{opc_sel_i[1]}} & {1'b0, add_out[DIV_WIDTH-1:0]}) |
		({XW{opc_sel_i[0]}} & {opc_r[DIV_WIDTH-1:0], ~add_out[DIV_WIDTH]});

	always_ff @(posedge clk_i) begin
		if (opa_ld_i) begin
			opa_r <= opa_mux;
		end
		if (opb_ld_i) begin
			opb_r <= opb_mux;
		end
		if (opc_ld_i) begin
			opc_r <= opc_mux;
		end
	end

	assign adder_neg_o = add_out[DIV_WIDTH];
	assign opa_neg_o = opa_r[DIV_WIDTH-1];
	assign opc_neg_o = opc_r[DIV_WIDTH-1];
	assign opa_o = opa_r;
	assign opc_o = opc_r[DIV_WIDTH-1:0];

endmodule

`default_nettype wire

// File: hdl/div_op_decode.sv
/*
 * Request side of the divider.
 * Ready needs an idle controller and a free output credit.
 * Operands and flags are held from acceptance until the next request.
 */

`timescale 1ns/100ps
`default_nettype none

module div_op_decode import div_pkg::*; (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 req_v_i,
	input  div_op_e              req_op_i,
	input  logic [DIV_WIDTH-1:0] req_a_i,
	input  logic [DIV_WIDTH-1:0] req_b_i,
	output logic                 req_ready_o,
	input  logic                 idle_i,
	input  logic                 credit_ok_i,
	output logic                 start_v_o,
	output logic                 signed_o,
	output logic                 want_rem_o,
	output logic [DIV_WIDTH-1:0] opa_in_o,
	output logic [DIV_WIDTH-1:0] opc_in_o
);

	logic op_signed;
	logic op_rem;

	assign req_ready_o = idle_i & credit_ok_i;
	assign start_v_o = req_v_i & req_ready_o;

	always_comb begin
		op_signed = 1'b0;
		op_rem = 1'b0;
		case (req_op_i)
			OP_DIV: op_signed = 1'b1;
			OP_REM: begin
				op_signed = 1'b1;
				op_rem = 1'b1;
			end
			OP_REMU: op_rem = 1'b1;
			default: op_signed = 1'b0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			signed_o <= 1'b0;
			want_rem_o <= 1'b0;
		end else if (start_v_o) begin
			signed_o <= op_signed;
			want_rem_o <= op_rem;
		end
	end

	// register A takes the divisor, register C the dividend.
	always_ff @(posedge clk_i) begin
		if (start_v_o) begin
			opa_in_o <= req_b_i;
			opc_in_o <= req_a_i;
		end
	end

endmodule

`default_nettype wire

// File: hdl/div_pkg.sv
/*
 * Shared definitions for the iterative divider.
 * DIV_WIDTH sets the operand width of every block; the datapath adds one
 * guard bit internally. DIV_CREDITS must match the consumer's buffer depth.
 */

`default_nettype none

package div_pkg;

	localparam int unsigned DIV_WIDTH = 32;
	localparam int unsigned DIV_CREDITS = 2;

	// step counter covers DIV_WIDTH+1 calculation cycles.
	localparam int unsigned DIV_CNT_W = $clog2(DIV_WIDTH + 1);
	localparam int unsigned DIV_CREDIT_W = $clog2(DIV_CREDITS + 1);

	typedef enum logic [1:0] {
		OP_DIV  = 2'd0,
		OP_DIVU = 2'd1,
		OP_REM  = 2'd2,
		OP_REMU = 2'd3
	} div_op_e;

	typedef enum logic [5:0] {
		S_WAIT,
		S_START,
		S_NEG0,
		S_NEG1,
		S_SHIFT,
		S_CALC,
		S_REPAIR,
		S_REMAIN,
		S_QUOT
	} div_state_e;

endpackage

`default_nettype wire

// File: hdl/div_result.sv
/*
 * Result register and output credit counter.
 * res_v_o lasts one cycle and the consumer must take the result then.
 * Each credit_i pulse returns one slot; the count starts at DIV_CREDITS.
 */

`timescale 1ns/100ps
`default_nettype none

module div_result import div_pkg::*; (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 done_i,
	input  logic                 want_rem_i,
	input  logic [DIV_WIDTH-1:0] quot_i,
	input  logic [DIV_WIDTH-1:0] rem_i,
	input  logic                 credit_i,
	output logic                 credit_ok_o,
	output logic                 res_v_o,
	output logic [DIV_WIDTH-1:0] res_data_o
);

	logic [DIV_CREDIT_W-1:0] credit_cnt_r;

	// no new request while a result is still leaving.
	assign credit_ok_o = (credit_cnt_r != '0) & ~res_v_o;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			res_v_o <= 1'b0;
		end else begin
			res_v_o <= done_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (done_i) begin
			res_data_o <= want_rem_i ? rem_i : quot_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			credit_cnt_r <= DIV_CREDIT_W'(DIV_CREDITS);
		end else begin
			case ({res_v_o, credit_i})
				2'b10: credit_cnt_r <= credit_cnt_r - 1'b1;
				2'b01: credit_cnt_r <= credit_cnt_r + 1'b1;
				default: credit_cnt_r <= credit_cnt_r;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/div_unit.sv
/*
 * Iterative 32-bit divider, one division in flight.
 * A result appears DIV_WIDTH+9 cycles after its request is accepted.
 */

`timescale 1ns/100ps
`default_nettype none

module div_unit import div_pkg::*; (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 req_v_i,
	input  div_op_e              req_op_i,
	input  logic [DIV_WIDTH-1:0] req_a_i,
	input  logic [DIV_WIDTH-1:0] req_b_i,
	output logic                 req_ready_o,
	output logic                 res_v_o,
	output logic [DIV_WIDTH-1:0] res_data_o,
	input  logic                 credit_i
);

	logic idle;
	logic credit_ok;
	logic start_v;
	logic signed_div;
	logic want_rem;
	logic done;
	logic [DIV_WIDTH-1:0] opa_in;
	logic [DIV_WIDTH-1:0] opc_in;
	logic [DIV_WIDTH-1:0] opa;
	logic [DIV_WIDTH-1:0] opc;
	logic adder_neg;
	logic opa_neg;
	logic opc_neg;
	logic opa_sel;
	logic opa_ld;
	logic opa_inv;
	logic opa_clr_l;
	logic [2:0] opb_sel;
	logic opb_ld;
	logic opb_inv;
	logic opb_clr_l;
	logic [2:0] opc_sel;
	logic opc_ld;
	logic adder_cin;

	div_op_decode decode0 (
		.clk_i(clk_i), .reset_i(reset_i),
		.req_v_i(req_v_i), .req_op_i(req_op_i),
		.req_a_i(req_a_i), .req_b_i(req_b_i),
		.req_ready_o(req_ready_o),
		.idle_i(idle), .credit_ok_i(credit_ok),
		.start_v_o(start_v), .signed_o(signed_div), .want_rem_o(want_rem),
		.opa_in_o(opa_in), .opc_in_o(opc_in)
	);

	div_controller ctrl0 (
		.clk_i(clk_i), .reset_i(reset_i),
		.start_v_i(start_v), .signed_i(signed_div),
		.adder_neg_i(adder_neg), .opa_neg_i(opa_neg), .opc_neg_i(opc_neg),
		.idle_o(idle), .done_o(done),
		.opa_sel_o(opa_sel), .opa_ld_o(opa_ld),
		.opa_inv_o(opa_inv), .opa_clr_l_o(opa_clr_l),
		.opb_sel_o(opb_sel), .opb_ld_o(opb_ld),
		.opb_inv_o(opb_inv), .opb_clr_l_o(opb_clr_l),
		.opc_sel_o(opc_sel), .opc_ld_o(opc_ld),
		.adder_cin_o(adder_cin)
	);

	div_datapath dpath0 (
		.clk_i(clk_i),
		.opa_in_i(opa_in), .opc_in_i(opc_in),
		.opa_sel_i(opa_sel), .opa_ld_i(opa_ld),
		.opa_inv_i(opa_inv), .opa_clr_l_i(opa_clr_l),
		.opb_sel_i(opb_sel), .opb_ld_i(opb_ld),
		.opb_inv_i(opb_inv), .opb_clr_l_i(opb_clr_l),
		.opc_sel_i(opc_sel), .opc_ld_i(opc_ld),
		.adder_cin_i(adder_cin),
		.adder_neg_o(adder_neg), .opa_neg_o(opa_neg), .opc_neg_o(opc_neg),
		.opa_o(opa), .opc_o(opc)
	);

	div_result result0 (
		.clk_i(clk_i), .reset_i(reset_i),
		.done_i(done), .want_rem_i(want_rem),
		.quot_i(opc), .rem_i(opa),
		.credit_i(credit_i), .credit_ok_o(credit_ok),
		.res_v_o(res_v_o), .res_data_o(res_data_o)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the divider testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module tb_div_unit -o tb_div_unit

status=0
./obj_dir/tb_div_unit +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed (exit status $status)"
	exit 1
fi

// File: tb/div_assertions.sv
/*
 * Handshake and credit assertions for div_unit, attached with bind.
 * outstanding mirrors results sent minus credits returned.
 */

`timescale 1ns/100ps
`default_nettype none

module div_assertions import div_pkg::*; (
	input logic                 clk_i,
	input logic                 reset_i,
	input logic                 req_v_i,
	input div_op_e              req_op_i,
	input logic [DIV_WIDTH-1:0] req_a_i,
	input logic [DIV_WIDTH-1:0] req_b_i,
	input logic                 req_ready_i,
	input logic                 res_v_i,
	input logic                 credit_i,
	input div_state_e           state_i
);

	int fail_cnt = 0;
	logic [3:0] outstanding;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			outstanding <= '0;
		end else begin
			outstanding <= outstanding + 4'(res_v_i) - 4'(credit_i);
		end
	end

	// an accepted request starts the controller and drops ready.
	a_start_busy: assert property (@(posedge clk_i) disable iff (reset_i)
		req_v_i && req_ready_i |=> !req_ready_i && state_i == S_START)
		else begin
			$error("accepted request did not start the controller");
			fail_cnt++;
		end

	// a waiting request keeps its fields.
	a_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
		req_v_i && !req_ready_i |=> req_v_i && $stable(req_op_i) &&
		$stable(req_a_i) && $stable(req_b_i))
		else begin
			$error("request changed before it was accepted");
			fail_cnt++;
		end

	a_res_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
		res_v_i |=> !res_v_i)
		else begin
			$error("result valid longer than one cycle");
			fail_cnt++;
		end

	a_credit_limit: assert property (@(posedge clk_i) disable iff (reset_i)
		outstanding <= 4'(DIV_CREDITS))
		else begin
			$error("more results outstanding than credits");
			fail_cnt++;
		end

	a_full_block: assert property (@(posedge clk_i) disable iff (reset_i)
		outstanding == 4'(DIV_CREDITS) |-> !req_ready_i)
		else begin
			$error("ready with no credit left");
			fail_cnt++;
		end

endmodule

bind div_unit div_assertions asrt0 (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.req_v_i(req_v_i),
	.req_op_i(req_op_i),
	.req_a_i(req_a_i),
	.req_b_i(req_b_i),
	.req_ready_i(req_ready_o),
	.res_v_i(res_v_o),
	.credit_i(credit_i),
	.state_i(ctrl0.state_r)
);

`default_nettype wire

// File: tb/div_checker.sv
/*
 * Scoreboard for div_unit. Ports are sampled on the falling clock edge,
 * where they are stable; the acceptance edge is the rising edge after.
 * Checks result values, request order, latency and credit use.
 */

`timescale 1ns/100ps
`default_nettype none

module div_checker import div_pkg::*; (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 req_v_i,
	input  div_op_e              req_op_i,
	input  logic [DIV_WIDTH-1:0] req_a_i,
	input  logic [DIV_WIDTH-1:0] req_b_i,
	input  logic                 req_ready_i,
	input  logic                 res_v_i,
	input  logic [DIV_WIDTH-1:0] res_data_i,
	input  logic                 credit_i,
	output int                   data_errs_o,
	output int                   proto_errs_o,
	output int                   pending_o
);

	localparam int LATENCY = int'(DIV_WIDTH) + 9;

	div_op_e op_q[$];
	logic [DIV_WIDTH-1:0] a_q[$];
	logic [DIV_WIDTH-1:0] b_q[$];
	logic [DIV_WIDTH-1:0] exp_q[$];
	int acc_q[$];
	int cycle = 0;
	int outstanding;
	div_op_e op_val;
	logic [DIV_WIDTH-1:0] a_val;
	logic [DIV_WIDTH-1:0] b_val;
	logic [DIV_WIDTH-1:0] exp_val;
	int acc_val;

	// reference model of the division rules.
	function automatic logic [DIV_WIDTH-1:0] model(input div_op_e op,
		input logic [DIV_WIDTH-1:0] a, input logic [DIV_WIDTH-1:0] b);
		logic overflow;
		overflow = (a == {1'b1, {(DIV_WIDTH-1){1'b0}}}) && (b == '1);
		case (op)
			OP_DIVU: model = (b == '0) ? '1 : a / b;
			OP_REMU: model = (b == '0) ? a : a % b;
			OP_DIV: begin
				if (b == '0) model = '1;
				else if (overflow) model = a;
				else model = $signed(a) / $signed(b);
			end
			default: begin
				if (b == '0) model = a;
				else if (overflow) model = '0;
				else model = $signed(a) % $signed(b);
			end
		endcase
	endfunction

	always @(posedge clk_i) begin
		cycle = cycle + 1;
	end

	always @(negedge clk_i) begin
		if (reset_i) begin
			data_errs_o = 0;
			proto_errs_o = 0;
			outstanding = 0;
		end else begin
			if (res_v_i) begin
				if (exp_q.size() == 0) begin
					$display("error at %0t: result %h arrived with no request pending",
						$time, res_data_i);
					proto_errs_o++;
				end else begin
					exp_val = exp_q.pop_front();
					op_val = op_q.pop_front();
					a_val = a_q.pop_front();
					b_val = b_q.pop_front();
					acc_val = acc_q.pop_front();
					if (res_data_i !== exp_val) begin
						$display("FAILED %0t: %s a=%h b=%h expected %h got %h", $time,
							op_val.name(), a_val, b_val, exp_val, res_data_i);
						data_errs_o++;
					end
					if (cycle - acc_val != LATENCY) begin
						$display("error at %0t: result came %0d cycles after acceptance, not %0d",
							$time, cycle - acc_val, LATENCY);
						proto_errs_o++;
					end
				end
				if (outstanding >= int'(DIV_CREDITS)) begin
					$display("error at %0t: result sent while no credit was free", $time);
					proto_errs_o++;
				end
				outstanding++;
			end
			if (credit_i) begin
				outstanding--;
			end
			if (req_ready_i && (outstanding + exp_q.size() >= int'(DIV_CREDITS))) begin
				$display("error at %0t: ready is high with every credit in use", $time);
				proto_errs_o++;
			end
			if (req_v_i && req_ready_i) begin
				op_q.push_back(req_op_i);
				a_q.push_back(req_a_i);
				b_q.push_back(req_b_i);
				exp_q.push_back(model(req_op_i, req_a_i, req_b_i));
				acc_q.push_back(cycle + 1);
			end
		end
		pending_o = exp_q.size();
	end

endmodule

`default_nettype wire

// File: tb/tb_div_unit.sv
/*
 * Testbench for div_unit: 300 random requests with biased operands.
 * The consumer returns each credit 0 to 20 cycles after its result;
 * requests 100 to 149 run with slow credit return to force back-pressure.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_div_unit import div_pkg::*; ();

	localparam int NUM_REQ = 300;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic reset;
	logic req_v;
	div_op_e req_op;
	logic [DIV_WIDTH-1:0] req_a;
	logic [DIV_WIDTH-1:0] req_b;
	logic req_ready;
	logic res_v;
	logic [DIV_WIDTH-1:0] res_data;
	logic credit = 1'b0;

	integer seed = 32'hd553;
	int cycle = 0;
	int credit_due[$];
	logic stall;
	int timeouts;
	int reset_errs;
	int data_errs;
	int proto_errs;
	int pending;
	int n;
	int gap;
	int waited;
	div_op_e op;
	logic [DIV_WIDTH-1:0] a;
	logic [DIV_WIDTH-1:0] b;
	logic [31:0] r;
	logic [31:0] delay_r;

	div_unit dut0 (
		.clk_i(clk), .reset_i(reset),
		.req_v_i(req_v), .req_op_i(req_op), .req_a_i(req_a), .req_b_i(req_b),
		.req_ready_o(req_ready),
		.res_v_o(res_v), .res_data_o(res_data),
		.credit_i(credit)
	);

	div_checker chk0 (
		.clk_i(clk), .reset_i(reset),
		.req_v_i(req_v), .req_op_i(req_op), .req_a_i(req_a), .req_b_i(req_b),
		.req_ready_i(req_ready),
		.res_v_i(res_v), .res_data_i(res_data), .credit_i(credit),
		.data_errs_o(data_errs), .proto_errs_o(proto_errs), .pending_o(pending)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// zero, minus one, most negative and small values come up often.
	task automatic pick_operand(output logic [DIV_WIDTH-1:0] val);
		logic [31:0] pick;
		pick = $random(seed);
		case (pick[2:0])
			3'd0: val = '0;
			3'd1: val = '1;
			3'd2: val = {1'b1, {(DIV_WIDTH-1){1'b0}}};
			3'd3: val = {{(DIV_WIDTH-4){pick[31]}}, pick[6:3]};
			default: val = $random(seed);
		endcase
	endtask

	task automatic send_request(input div_op_e op_v, input logic [DIV_WIDTH-1:0] a_v,
		input logic [DIV_WIDTH-1:0] b_v);
		int tries;
		req_v = 1'b1;
		req_op = op_v;
		req_a = a_v;
		req_b = b_v;
		tries = 0;
		@(negedge clk);
		while (!req_ready && tries < WAIT_LIMIT) begin
			@(negedge clk);
			tries++;
		end
		if (!req_ready) begin
			$display("timeout: request was not accepted within %0d cycles", WAIT_LIMIT);
			timeouts++;
		end
		@(posedge clk);
		#1;
		req_v = 1'b0;
	endtask

	// each result frees its credit after a random delay.
	always @(negedge clk) begin
		if (!reset && res_v) begin
			delay_r = $random(seed);
			credit_due.push_back(cycle + 1 + int'(delay_r % 21) + (stall ? 60 : 0));
			credit_due.sort();
		end
	end

	always @(posedge clk) begin
		cycle = cycle + 1;
		#1;
		credit = 1'b0;
		if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
			void'(credit_due.pop_front());
			credit = 1'b1;
		end
	end

	initial begin
		reset = 1'b1;
		req_v = 1'b0;
		req_op = OP_DIVU;
		req_a = '0;
		req_b = '0;
		stall = 1'b0;
		timeouts = 0;
		reset_errs = 0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		if (!req_ready || res_v) begin
			$display("error after reset: ready is %b and result valid is %b", req_ready, res_v);
			reset_errs++;
		end
		@(posedge clk);
		#1;
		for (n = 0; n < NUM_REQ && timeouts == 0; n++) begin
			stall = (n >= 100 && n < 150);
			r = $random(seed);
			gap = int'(r[7:6]);
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			op = div_op_e'(r[1:0]);
			pick_operand(a);
			pick_operand(b);
			send_request(op, a, b);
		end
		waited = 0;
		while (pending > 0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (pending > 0) begin
			$display("timeout: %0d results still missing after the last request", pending);
			timeouts++;
		end
		repeat (5) @(negedge clk);
		$display("errors: data %0d, protocol %0d, reset %0d, assertion %0d, timeout %0d",
			data_errs, proto_errs, reset_errs, dut0.asrt0.fail_cnt, timeouts);
		if (data_errs + proto_errs + reset_errs + dut0.asrt0.fail_cnt + timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
hdl/div_pkg.sv
hdl/div_op_decode.sv
hdl/div_controller.sv
hdl/div_datapath.sv
hdl/div_result.sv
hdl/div_unit.sv
tb/div_checker.sv
tb/div_assertions.sv
tb/tb_div_unit.sv
